//--- rtl/isa_pkg.sv
// Instruction encoding only; opcodes above BEQ carry no meaning and run as no-ops in the core
package isa_pkg;

    // Field widths of the 32-bit instruction word
    localparam int INSTR_W   = 32;
    localparam int OPCODE_W  = 8;
    localparam int REG_IDX_W = 3;
    localparam int OPERAND_W = 8;  // Source 2 index and immediate share this byte
    localparam int OFFSET_W  = 8;

    localparam int OFFSET_SHIFT = 2;  // Branch offset counts words

    // Unused gaps in each view
    localparam int OPER_PAD_HI_W = 5;
    localparam int OPER_PAD_LO_W = 5;
    localparam int BR_PAD_W      = INSTR_W - OPCODE_W - OFFSET_W;

    typedef enum logic [OPCODE_W-1:0] {
        LOADI = 8'd0,
        MOV   = 8'd1,
        ADD   = 8'd2,
        SUB   = 8'd3,
        AND   = 8'd4,
        OR    = 8'd5,
        JUMP  = 8'd6,
        BEQ   = 8'd7
    } opcode_t;

    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    // Register and immediate instructions
    typedef struct packed {
        opcode_t                  opcode;   // 31..24
        logic [OPER_PAD_HI_W-1:0] pad_hi;   // 23..19
        reg_idx_t                 dest;     // 18..16
        logic [OPER_PAD_LO_W-1:0] pad_lo;   // 15..11
        reg_idx_t                 src1;     // 10..8
        logic [OPERAND_W-1:0]     operand;  // Low bits name source 2
    } oper_view_t;

    // JUMP and BEQ read the offset from the destination byte
    typedef struct packed {
        opcode_t                     opcode;
        logic signed [OFFSET_W-1:0]  offset;  // 23..16
        logic [BR_PAD_W-1:0]         pad;
    } branch_view_t;

    // Same word seen two ways
    typedef union packed {
        oper_view_t   oper;
        branch_view_t br;
    } instr_u;

endpackage

//--- rtl/core_pkg.sv
// Datapath types for a single-cycle core with no data memory; register write-back is the only result bus
package core_pkg;

    localparam int DATA_W   = 8;
    localparam int PC_W     = 32;
    localparam int NUM_REGS = 8;
    localparam int PC_STEP  = 4;  // Byte address of the next word

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [PC_W-1:0]   pc_t;

    // ALU functions
    typedef enum logic [1:0] {
        ALU_FWD = 2'd0,  // Pass the second operand
        ALU_ADD = 2'd1,
        ALU_AND = 2'd2,
        ALU_OR  = 2'd3
    } alu_op_t;

    // Control bundle from the decoder
    typedef struct packed {
        alu_op_t alu_op;
        logic    negate;     // Two's complement of operand 2
        logic    use_imm;    // Immediate replaces operand 2
        logic    reg_write;
        logic    branch;
        logic    jump;
    } ctrl_t;

    // Register write-back, committed at the next edge when valid
    typedef struct packed {
        logic              valid;
        isa_pkg::reg_idx_t dest;
        data_t             data;
    } wb_t;

endpackage

//--- rtl/instr_decoder.sv
// Purely combinational opcode decode; the clock and reset only serve the bundle check
`timescale 1ns/1ps

module instr_decoder (
    input  logic            CLK,
    input  logic            RESET,
    input  isa_pkg::instr_u instr,
    output core_pkg::ctrl_t ctrl
);

    import isa_pkg::*;
    import core_pkg::*;

    always_comb begin
        ctrl = '0;  // Anything unlisted is a no-op

        case (instr.oper.opcode)
            LOADI: begin
                ctrl.alu_op    = ALU_FWD;
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            MOV: begin
                ctrl.alu_op    = ALU_FWD;
                ctrl.reg_write = 1'b1;
            end
            ADD: begin
                ctrl.alu_op    = ALU_ADD;
                ctrl.reg_write = 1'b1;
            end
            SUB: begin
                ctrl.alu_op    = ALU_ADD;  // Add the negated operand
                ctrl.negate    = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            AND: begin
                ctrl.alu_op    = ALU_AND;
                ctrl.reg_write = 1'b1;
            end
            OR: begin
                ctrl.alu_op    = ALU_OR;
                ctrl.reg_write = 1'b1;
            end
            JUMP: begin
                ctrl.jump = 1'b1;
            end
            BEQ: begin
                // Compare by subtraction, result only feeds the zero test
                ctrl.alu_op = ALU_ADD;
                ctrl.negate = 1'b1;
                ctrl.branch = 1'b1;
            end
            default: begin
                ctrl = '0;
            end
        endcase
    end

    // A write never goes with a change of flow
    assert property (@(posedge CLK) disable iff (RESET)
        $onehot0({ctrl.reg_write, ctrl.branch, ctrl.jump}))
    else $error("Decoder raised more than one of write, branch and jump");

endmodule

//--- rtl/reg_file.sv
// Eight registers with async reads and one write per clock; writes show after the edge
`timescale 1ns/1ps

module reg_file (
    input  logic              CLK,
    input  logic              RESET,
    input  isa_pkg::reg_idx_t rd_idx1,
    input  isa_pkg::reg_idx_t rd_idx2,
    output core_pkg::data_t   rd_data1,
    output core_pkg::data_t   rd_data2,
    input  core_pkg::wb_t     wb
);

    import core_pkg::*;

    data_t regs [NUM_REGS];

    // Read ports
    assign rd_data1 = regs[rd_idx1];
    assign rd_data2 = regs[rd_idx2];

    // Write port
    always_ff @(posedge CLK) begin
        if (RESET) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid) begin
            regs[wb.dest] <= wb.data;
        end
    end

endmodule

//--- rtl/execute_unit.sv
// Combinational execute stage; BEQ uses the same subtract path as SUB and never writes a register
`timescale 1ns/1ps

module execute_unit (
    input  isa_pkg::instr_u instr,
    input  core_pkg::ctrl_t ctrl,
    input  core_pkg::data_t rd_data1,
    input  core_pkg::data_t rd_data2,
    output core_pkg::wb_t   wb,
    output logic            take_target
);

    import core_pkg::*;

    data_t negated;     // Two's complement of source 2
    data_t operand_b;
    data_t alu_result;
    logic  zero;

    assign negated = ~rd_data2 + data_t'(1);

    // Immediate wins over the register path
    always_comb begin
        if (ctrl.use_imm) begin
            operand_b = instr.oper.operand;
        end else if (ctrl.negate) begin
            operand_b = negated;
        end else begin
            operand_b = rd_data2;
        end
    end

    // ALU
    always_comb begin
        case (ctrl.alu_op)
            ALU_FWD: alu_result = operand_b;
            ALU_ADD: alu_result = rd_data1 + operand_b;  // Wraps at 8 bits
            ALU_AND: alu_result = rd_data1 & operand_b;
            ALU_OR:  alu_result = rd_data1 | operand_b;
            default: alu_result = operand_b;
        endcase
    end

    assign zero = (alu_result == '0);

    // Write-back bundle
    assign wb.valid = ctrl.reg_write;
    assign wb.dest  = instr.oper.dest;
    assign wb.data  = alu_result;

    // Jump always, branch only on equal operands
    assign take_target = ctrl.jump | (ctrl.branch & zero);

endmodule

//--- rtl/next_pc_unit.sv
// PC register with relative jumps from PC+4; the target wraps silently at 32 bits
`timescale 1ns/1ps

module next_pc_unit (
    input  logic            CLK,
    input  logic            RESET,
    input  isa_pkg::instr_u instr,
    input  logic            take_target,
    output core_pkg::pc_t   pc
);

    import isa_pkg::*;
    import core_pkg::*;

    pc_t pc_seq;       // Address of the following word
    pc_t offset_ext;   // Offset in bytes
    pc_t target;

    assign pc_seq = pc + pc_t'(PC_STEP);

    // Sign extend, then scale words to bytes
    assign offset_ext = {{(PC_W - OFFSET_W){instr.br.offset[OFFSET_W-1]}}, instr.br.offset}
                        << OFFSET_SHIFT;

    assign target = pc_seq + offset_ext;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            pc <= '0;
        end else if (take_target) begin
            pc <= target;
        end else begin
            pc <= pc_seq;
        end
    end

    // Fetch stays word aligned
    assert property (@(posedge CLK) disable iff (RESET) pc[1:0] == 2'b00)
    else $error("PC lost word alignment");

endmodule

//--- rtl/cpu_core.sv
// Single-cycle core top; the instruction must be stable for the whole cycle that pc selects it
`timescale 1ns/1ps

module cpu_core (
    input  logic            CLK,
    input  logic            RESET,
    input  isa_pkg::instr_u instr,
    output core_pkg::pc_t   pc,
    output core_pkg::wb_t   wb
);

    import isa_pkg::*;
    import core_pkg::*;

    ctrl_t ctrl;
    data_t rd_data1;
    data_t rd_data2;
    logic  take_target;

    // Decode and register read run side by side
    instr_decoder u_decoder (
        .CLK   (CLK),
        .RESET (RESET),
        .instr (instr),
        .ctrl  (ctrl)
    );

    reg_file u_reg_file (
        .CLK      (CLK),
        .RESET    (RESET),
        .rd_idx1  (instr.oper.src1),
        .rd_idx2  (instr.oper.operand[REG_IDX_W-1:0]),  // Source 2 is the low bits
        .rd_data1 (rd_data1),
        .rd_data2 (rd_data2),
        .wb       (wb)
    );

    execute_unit u_execute (
        .instr       (instr),
        .ctrl        (ctrl),
        .rd_data1    (rd_data1),
        .rd_data2    (rd_data2),
        .wb          (wb),
        .take_target (take_target)
    );

    next_pc_unit u_next_pc (
        .CLK         (CLK),
        .RESET       (RESET),
        .instr       (instr),
        .take_target (take_target),
        .pc          (pc)
    );

endmodule

//--- verif/tb_cpu_core.sv
// Data file path is relative to the project root; fetch follows the expected pc trace
`timescale 1ns/1ps

module tb_cpu_core;

    import isa_pkg::*;
    import core_pkg::*;

    localparam int    CLK_PERIOD      = 20;
    localparam int    RESET_CYCLES    = 2;
    localparam int    WATCHDOG_MARGIN = 10;   // Cycles allowed beyond the trace
    localparam int    MEM_DEPTH       = 512;
    localparam int    MAX_PROG        = 64;
    localparam int    MAX_TRACE       = 64;
    localparam int    REC_WORDS       = 4;    // pc, valid, dest, data
    localparam int    SEED            = 61202;
    localparam string INPUT_FILE      = "verif/program_input.mem";

    localparam logic [31:0] NOOP_WORD = 32'hFF00_0000;  // Opcode outside the ISA

    logic   CLK;
    logic   RESET;
    instr_u instr;
    pc_t    pc;
    wb_t    wb;

    // Raw data file image and the tables unpacked from it
    logic [31:0] mem_words   [MEM_DEPTH];
    logic [31:0] rom         [MAX_PROG];
    pc_t         trace_pc    [MAX_TRACE];
    logic        trace_valid [MAX_TRACE];
    reg_idx_t    trace_dest  [MAX_TRACE];
    data_t       trace_data  [MAX_TRACE];
    int          prog_count;
    int          trace_count;
    logic        stimulus_loaded;

    cpu_core u_dut (
        .CLK   (CLK),
        .RESET (RESET),
        .instr (instr),
        .pc    (pc),
        .wb    (wb)
    );

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    // Compare one DUT value with its expected value
    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Fail at %0d ns: %s is %h, expected %h", $time, name, actual, expected);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    // Split the file image into program ROM and trace records
    task automatic load_stimulus();
        int base;

        $readmemh(INPUT_FILE, mem_words);
        if ($isunknown(mem_words[0]) || mem_words[0] == 0 || mem_words[0] > MAX_PROG) begin
            $display("Error: program count in %s is missing or out of range", INPUT_FILE);
            $display("Simulation failed");
            $fatal(1);
        end
        prog_count = int'(mem_words[0]);
        for (int i = 0; i < prog_count; i++) begin
            rom[i] = mem_words[i + 1];
        end

        base = prog_count + 1;  // Trace count follows the last program word
        if ($isunknown(mem_words[base]) || mem_words[base] == 0 ||
            mem_words[base] > MAX_TRACE) begin
            $display("Error: trace count in %s is missing or out of range", INPUT_FILE);
            $display("Simulation failed");
            $fatal(1);
        end
        trace_count = int'(mem_words[base]);
        base = base + 1;

        for (int i = 0; i < trace_count; i++) begin
            trace_pc[i]    = mem_words[base + REC_WORDS * i];
            trace_valid[i] = mem_words[base + REC_WORDS * i + 1][0];
            trace_dest[i]  = mem_words[base + REC_WORDS * i + 2][2:0];
            trace_data[i]  = mem_words[base + REC_WORDS * i + 3][7:0];
        end
    endtask

    // ROM lookup by byte address
    function automatic logic [31:0] fetch_word(input pc_t addr);
        logic [31:0] index;
        logic [7:0]  opcode;

        index = addr >> 2;
        if (index < 32'(prog_count)) begin
            return rom[index];
        end else begin
            // Beyond the program, some opcode above BEQ with random fields
            opcode = 8'(int'(BEQ) + 1 + int'($urandom_range(254 - int'(BEQ), 0)));
            return {opcode, 24'($urandom)};
        end
    endfunction

    initial begin
        void'($urandom(SEED));
        stimulus_loaded = 1'b0;
        RESET <= 1'b1;
        instr <= NOOP_WORD;

        load_stimulus();
        stimulus_loaded = 1'b1;

        repeat (RESET_CYCLES) @(posedge CLK);
        RESET <= 1'b0;
        instr <= fetch_word(trace_pc[0]);

        for (int i = 0; i < trace_count; i++) begin
            @(negedge CLK);  // Mid-cycle, wb has settled
            check_value("pc", pc, trace_pc[i]);
            check_value("wb.valid", 32'(wb.valid), 32'(trace_valid[i]));
            if (trace_valid[i]) begin
                check_value("wb.dest", 32'(wb.dest), 32'(trace_dest[i]));
                check_value("wb.data", 32'(wb.data), 32'(trace_data[i]));
            end
            if (i + 1 < trace_count) begin
                @(posedge CLK);
                instr <= fetch_word(trace_pc[i + 1]);
            end
        end

        $display("Simulation passed");
        $finish;
    end

    // Watchdog sized from the trace length
    initial begin
        wait (stimulus_loaded === 1'b1);
        #(CLK_PERIOD * (trace_count + RESET_CYCLES + WATCHDOG_MARGIN));
        $display("Error: watchdog expired before all %0d trace records were checked",
                 trace_count);
        $display("Simulation failed");
        $fatal(1);
    end

endmodule

//--- verif/program_input.mem
// Program word count, program words, then trace record count and trace records
// Trace columns: pc valid dest data, where dest and data count only when valid is 1
19
FF000000 // no-op right after reset
01010003 // MOV r1, r3 from a cleared register
0002005A // LOADI r2, 5A
01040002 // MOV r4, r2
000500C3 // LOADI r5, C3
0006007E // LOADI r6, 7E
02070506 // ADD r7, r5, r6 overflows
03010605 // SUB r1, r6, r5 wraps below zero
04030506 // AND r3, r5, r6
05000506 // OR r0, r5, r6
06020000 // JUMP +2
000100EE // skipped
000200EE // skipped
07010402 // BEQ r4, r2, +1 taken
000700EE // skipped
07030506 // BEQ r5, r6, +3 not taken
9A070102 // unknown opcode
00010002 // LOADI r1, 02 loop counter
000200FF // LOADI r2, FF
00000000 // LOADI r0, 00
02010102 // ADD r1, r1, r2
07010100 // BEQ r1, r0, +1 leaves the loop
06FD0000 // JUMP -3 back to the ADD
01060001 // MOV r6, r1
05050703 // OR r5, r7, r3 shows r7 kept its value
1A
00000000 0 0 00
00000004 1 1 00
00000008 1 2 5A
0000000C 1 4 5A
00000010 1 5 C3
00000014 1 6 7E
00000018 1 7 41
0000001C 1 1 BB
00000020 1 3 42
00000024 1 0 FF
00000028 0 0 00
00000034 0 0 00
0000003C 0 0 00
00000040 0 0 00
00000044 1 1 02
00000048 1 2 FF
0000004C 1 0 00
00000050 1 1 01
00000054 0 0 00
00000058 0 0 00
00000050 1 1 00
00000054 0 0 00
0000005C 1 6 00
00000060 1 5 43
00000064 0 0 00
00000068 0 0 00

//--- cpu8_core.f
rtl/isa_pkg.sv
rtl/core_pkg.sv
rtl/instr_decoder.sv
rtl/reg_file.sv
rtl/execute_unit.sv
rtl/next_pc_unit.sv
rtl/cpu_core.sv
verif/tb_cpu_core.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it; the exit status is the simulation result

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -f cpu8_core.f --top-module tb_cpu_core \
    -Mdir obj_dir -o tb_cpu_core \
    && ./obj_dir/tb_cpu_core \
    || { echo "Build or simulation ended with an error" >&2; exit 1; }
